// ==== tetris.f ====
tetris_pkg.sv
piece_spawner.sv
piece_faller.sv
board_merger.sv
tetris_core.sv
tb_clock.sv
tetris_tb.sv

// ==== Makefile ====
SRCS := $(shell cat tetris.f)

obj_dir/Vtetris_tb: $(SRCS) tetris.f
	verilator --binary --assert --timing --top-module tetris_tb -f tetris.f

run: obj_dir/Vtetris_tb
	./obj_dir/Vtetris_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== tetris_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module tetris_tb import tetris_pkg::*; ;

    logic clk, reset, drop, move_left, move_right;
    board_t display;
    logic game_over;
    line_count_t lines_cleared;
    string test_name = "reset";

    // Reference model state, updated on the same edges as the DUT
    int          m_credit;
    logic        m_fire, m_spawn_valid, m_credit_ret, m_land_valid;
    shape_idx_t  m_next;
    board_t      m_spawn_mask, m_live, m_stored, m_compact;
    fall_state_t m_state;
    line_count_t m_lines, m_removed;
    board_t      exp_display;

    tb_clock clock_gen (.clk(clk));

    tetris_core UUT (
        .clk(clk), .reset(reset), .drop(drop), .move_left(move_left),
        .move_right(move_right), .display(display), .game_over(game_over),
        .lines_cleared(lines_cleared)
    );

    function automatic board_t spawn_mask(input shape_idx_t idx);
        board_t b;
        b    = '0;
        b[0] = shape_rows[idx][0];  // Top two rows only
        b[1] = shape_rows[idx][1];
        return b;
    endfunction

    function automatic logic free(input board_t m, input board_t s);
        return (m & s) == '0;
    endfunction

    // Keep non-full rows in order, pack them against the floor
    function automatic board_t compact(input board_t b, output line_count_t n);
        board_t res;
        int k;
        res = '0;
        n   = '0;
        k   = board_rows - 1;
        for (int r = board_rows - 1; r >= 0; r--) begin
            if (b[r] == {board_cols{1'b1}}) n = n + 8'd1;
            else begin
                res[k] = b[r];
                k = k - 1;
            end
        end
        return res;
    endfunction

    assign m_fire      = (m_credit > 0) || m_credit_ret;  // Returned credit spent at once
    assign exp_display = m_stored | m_live;
    always_comb m_compact = compact(m_stored | m_live, m_removed);

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            m_credit <= max_credit;
            {m_spawn_valid, m_credit_ret, m_land_valid} <= 3'b000;
            m_next <= '0;
            m_spawn_mask <= '0;
            m_live <= '0;
            m_stored <= '0;
            m_lines <= '0;
            m_state <= idle;
        end else begin
            m_spawn_valid <= m_fire;
            m_credit      <= m_credit + (m_credit_ret ? 1 : 0) - (m_fire ? 1 : 0);
            if (m_fire) begin
                m_spawn_mask <= spawn_mask(m_next);
                m_next       <= (m_next == 3'd6) ? 3'd0 : m_next + 3'd1;
            end
            m_land_valid <= 1'b0;
            m_credit_ret <= 1'b0;
            if (m_land_valid) begin  // Piece moves into the stored board
                m_live   <= '0;
                m_stored <= m_compact;
                m_lines  <= m_lines + m_removed;
            end
            if (m_state == idle && m_spawn_valid) begin
                if (free(m_spawn_mask, m_stored)) begin
                    m_live  <= m_spawn_mask;
                    m_state <= falling;
                end else m_state <= over;
            end else if (m_state == falling) begin
                if (drop) begin
                    if (m_live[board_rows-1] == '0 && free({m_live[board_rows-2:0], row_t'(0)},
                                                          m_stored))
                        m_live <= {m_live[board_rows-2:0], row_t'(0)};
                    else begin
                        m_land_valid <= 1'b1;
                        m_credit_ret <= 1'b1;
                        m_state      <= idle;
                    end
                end else if (move_left || move_right) begin
                    board_t lt, rt;
                    logic   at_left, at_right;  // Piece touches a wall
                    at_left  = |(m_live & {board_rows{row_t'(1)}});
                    at_right = |(m_live & {board_rows{row_t'(1) << (board_cols - 1)}});
                    for (int r = 0; r < board_rows; r++) begin
                        lt[r] = m_live[r] >> 1;
                        rt[r] = m_live[r] << 1;
                    end
                    if (move_left && !at_left && free(lt, m_stored))
                        m_live <= lt;
                    else if (move_right && !at_right && free(rt, m_stored))
                        m_live <= rt;  // Right still acts when left is blocked
                end
            end
        end
    end

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // Checks sampled on every rising edge
    assert property (@(posedge clk) reset |-> display == '0 && !game_over && lines_cleared == 0)
        else report_fail($sformatf(
            "mismatch %s outputs in reset expected 0 0 0 actual %h %b %0d", test_name,
            $sampled(display), $sampled(game_over), $sampled(lines_cleared)));
    assert property (@(posedge clk) disable iff (reset) display == exp_display)
        else report_fail($sformatf("mismatch %s display expected %h actual %h", test_name,
                                   $sampled(exp_display), $sampled(display)));
    assert property (@(posedge clk) disable iff (reset) game_over == (m_state == over))
        else report_fail($sformatf("mismatch %s game_over expected %b actual %b", test_name,
                                   $sampled(m_state == over), $sampled(game_over)));
    assert property (@(posedge clk) disable iff (reset) lines_cleared == m_lines)
        else report_fail($sformatf("mismatch %s lines_cleared expected %0d actual %0d",
                                   test_name, $sampled(m_lines), $sampled(lines_cleared)));
    assert property (@(posedge clk) disable iff (reset) UUT.spawn_valid == m_spawn_valid)
        else report_fail($sformatf("mismatch %s spawn_valid expected %b actual %b", test_name,
                                   $sampled(m_spawn_valid), $sampled(UUT.spawn_valid)));
    assert property (@(posedge clk) disable iff (reset) m_state == over |=> $stable(display))
        else report_fail("display changed after game over");

    task automatic step(input logic d, input logic l, input logic r);
        @(posedge clk);
        drop       <= d;
        move_left  <= l;
        move_right <= r;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (10) step(1'b0, 1'b0, 1'b0);
        reset <= 1'b0;
    endtask

    // Wait for a live piece or for game over
    task automatic wait_live();
        int n;
        n = 0;
        @(negedge clk);
        while (m_state == idle) begin
            if (n == 50) report_fail("no piece spawned within 50 cycles");
            n++;
            @(negedge clk);
        end
    endtask

    task automatic move(input logic l, input int count);
        wait_live();
        repeat (count) step(1'b0, l, !l);
        step(1'b0, 1'b0, 1'b0);
    endtask

    task automatic drop_to_floor();
        int n;
        n = 0;
        wait_live();
        while (m_state == falling) begin
            if (n == 40) report_fail("piece did not land after 40 drops");
            n++;
            step(1'b1, 1'b0, 1'b0);
            @(negedge clk);
        end
        step(1'b0, 1'b0, 1'b0);
    endtask

    initial begin
        repeat (20000) @(posedge clk);  // Sum of all tests plus margin
        $display("watchdog expired before the tests finished");
        $display("Test FAILED");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'hfef6879e));
        {reset, drop, move_left, move_right} = 4'b1000;
        apply_reset();
        test_name = "spawn_order";
        repeat (8) drop_to_floor();  // Wraps past L
        apply_reset();
        test_name = "movement";
        move(1'b1, 5);  // Three steps, then the wall
        move(1'b0, 8);
        move(1'b1, 9);
        drop_to_floor();
        move(1'b1, 6);
        drop_to_floor();
        wait_live();
        repeat (18) step(1'b1, 1'b0, 1'b0);
        move(1'b1, 6);  // Pushes into stored cells
        drop_to_floor();
        apply_reset();
        test_name = "line_clear";
        move(1'b1, 3);  // I to columns 0 to 3
        drop_to_floor();
        move(1'b0, 5);  // O to columns 8 to 9
        drop_to_floor();
        repeat (5) begin  // T S Z J L stacked on the left
            move(1'b1, 4);
            drop_to_floor();
        end
        move(1'b0, 1);  // I into columns 4 to 7
        drop_to_floor();
        wait_live();
        if (lines_cleared != 8'd1) report_fail($sformatf(
            "mismatch line_clear lines_cleared expected 1 actual %0d", lines_cleared));
        test_name = "random";
        repeat (400) step($urandom % 3 == 0, $urandom % 3 == 0, $urandom % 3 == 0);
        apply_reset();
        test_name = "game_over";
        repeat (30) if (m_state != over) drop_to_floor();
        repeat (40) step($urandom % 2 == 0, $urandom % 2 == 0, $urandom % 2 == 0);
        if (!game_over) report_fail("game over never reached by centre stacking");
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #5 clk = ~clk;  // 10 ns period

endmodule

`default_nettype wire

// ==== tetris_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tetris_core import tetris_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        drop,        // One-cycle strobes
    input  logic        move_left,
    input  logic        move_right,
    output board_t      display,     // Stored cells plus live piece
    output logic        game_over,   // Sticky until reset
    output line_count_t lines_cleared
);

    // Spawn to fall, credit handshake
    logic   spawn_valid;
    piece_t spawn_piece;
    logic   credit_return;

    // Fall to merge
    logic   land_valid;
    piece_t land_piece;
    board_t stored_board;
    board_t live_board;

    piece_spawner u_spawner (
        .clk           (clk),
        .reset         (reset),
        .credit_return (credit_return),
        .spawn_valid   (spawn_valid),
        .spawn_piece   (spawn_piece)
    );

    piece_faller u_faller (
        .clk           (clk),
        .reset         (reset),
        .spawn_valid   (spawn_valid),
        .spawn_piece   (spawn_piece),
        .drop          (drop),
        .move_left     (move_left),
        .move_right    (move_right),
        .stored_board  (stored_board),
        .live_board    (live_board),
        .land_valid    (land_valid),
        .credit_return (credit_return),
        .land_piece    (land_piece),
        .game_over     (game_over)
    );

    board_merger u_merger (
        .clk           (clk),
        .reset         (reset),
        .land_valid    (land_valid),
        .land_piece    (land_piece),
        .stored_board  (stored_board),
        .lines_cleared (lines_cleared)
    );

    // Cells never overlap, so OR is a plain union
    assign display = stored_board | live_board;

endmodule

`default_nettype wire

// ==== board_merger.sv ====
`timescale 1ns/10ps
`default_nettype none

module board_merger import tetris_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        land_valid,     // Always accepted
    input  piece_t      land_piece,
    output board_t      stored_board,
    output line_count_t lines_cleared
);

    board_t      merged;     // Stored board plus landed piece
    board_t      compacted;  // Merged board with full rows gone
    line_count_t removed;    // Full rows in merged

    // Walk from the floor up, copying only rows that are not full
    always_comb begin
        int dst;
        merged    = stored_board | land_piece.mask;
        compacted = '0;  // Empty rows fill in at the top
        removed   = '0;
        dst       = board_rows - 1;
        for (int src = board_rows - 1; src >= 0; src--) begin
            if (&merged[src]) begin
                removed = removed + 8'd1;  // Full, skip it
            end else begin
                compacted[dst] = merged[src];
                dst            = dst - 1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stored_board  <= '0;
            lines_cleared <= '0;
        end else if (land_valid) begin
            stored_board  <= compacted;
            lines_cleared <= lines_cleared + removed;  // Wraps
        end
    end

    // Faller must hand over a legal shape that fits the stored cells
    assert property (@(posedge clk) disable iff (reset)
        land_valid |-> ((land_piece.mask & stored_board) == '0)
                       && (land_piece.shape < shape_idx_t'(num_shapes)));

endmodule

`default_nettype wire

// ==== piece_faller.sv ====
`timescale 1ns/10ps
`default_nettype none

module piece_faller import tetris_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   spawn_valid,
    input  piece_t spawn_piece,
    input  logic   drop,          // Move down one row
    input  logic   move_left,
    input  logic   move_right,
    input  board_t stored_board,  // Landed cells, for collisions
    output board_t live_board,
    output logic   land_valid,    // Piece handed to the merger
    output logic   credit_return,
    output piece_t land_piece,
    output logic   game_over
);

    fall_state_t state;
    piece_t      live_piece;

    board_t down_mask, left_mask, right_mask;
    logic   down_ok, left_ok, right_ok;
    logic   spawn_hit;  // Spawned piece lands on stored cells

    // Shift every row toward the floor
    function automatic board_t shift_down(input board_t m);
        return {m[board_rows-2:0], row_t'(0)};
    endfunction

    // Column 0 is bit 0, so left is a right shift
    function automatic board_t shift_left(input board_t m);
        board_t r;
        for (int i = 0; i < board_rows; i++)
            r[i] = m[i] >> 1;
        return r;
    endfunction

    function automatic board_t shift_right(input board_t m);
        board_t r;
        for (int i = 0; i < board_rows; i++)
            r[i] = m[i] << 1;
        return r;
    endfunction

    // Any cell in the given column
    function automatic logic col_used(input board_t m, input int col);
        logic u;
        u = 1'b0;
        for (int i = 0; i < board_rows; i++)
            u |= m[i][col];
        return u;
    endfunction

    assign down_mask  = shift_down(live_piece.mask);
    assign left_mask  = shift_left(live_piece.mask);
    assign right_mask = shift_right(live_piece.mask);

    // Edge check first, then overlap with stored cells
    assign down_ok  = (live_piece.mask[board_rows-1] == '0) && ((down_mask & stored_board) == '0);
    assign left_ok  = !col_used(live_piece.mask, 0) && ((left_mask & stored_board) == '0);
    assign right_ok = !col_used(live_piece.mask, board_cols - 1)
                      && ((right_mask & stored_board) == '0);

    assign spawn_hit = ((spawn_piece.mask & stored_board) != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= idle;
            live_piece    <= '0;
            land_valid    <= 1'b0;
            credit_return <= 1'b0;
            game_over     <= 1'b0;
        end else begin
            land_valid    <= 1'b0;  // Pulses by default
            credit_return <= 1'b0;
            // Merger has the piece now, drop the live copy
            if (land_valid)
                live_piece.mask <= '0;
            case (state)
                idle: begin
                    if (spawn_valid) begin
                        if (spawn_hit) begin
                            state     <= over;  // No room at the top
                            game_over <= 1'b1;
                        end else begin
                            live_piece <= spawn_piece;
                            state      <= falling;
                        end
                    end
                end
                falling: begin
                    if (drop) begin  // Drop beats moves
                        if (down_ok) begin
                            live_piece.mask <= down_mask;
                        end else begin
                            land_valid    <= 1'b1;  // Piece stays live one more cycle
                            credit_return <= 1'b1;
                            state         <= idle;
                        end
                    end else if (move_left && left_ok) begin
                        live_piece.mask <= left_mask;
                    end else if (move_right && right_ok) begin
                        live_piece.mask <= right_mask;
                    end
                end
                default: ;  // over is final until reset
            endcase
        end
    end

    assign live_board = live_piece.mask;
    assign land_piece = live_piece;  // Valid with land_valid

    // Landing hands over a real piece, never an empty slot
    assert property (@(posedge clk) disable iff (reset)
        land_valid |-> live_piece.mask != '0);

    // Live piece and merged board never share a cell
    assert property (@(posedge clk) disable iff (reset)
        (live_piece.mask & stored_board) == '0);

endmodule

`default_nettype wire

// ==== piece_spawner.sv ====
`timescale 1ns/10ps
`default_nettype none

module piece_spawner import tetris_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   credit_return,  // One piece slot freed in the faller
    output logic   spawn_valid,    // One-cycle spawn strobe
    output piece_t spawn_piece
);

    logic [1:0] credit;         // Free slots in the faller
    logic [1:0] credit_avail;   // Slots including a return this cycle
    logic       fire;           // Spawn at this edge
    shape_idx_t shape_idx;      // Next shape to spawn
    board_t     shape_mask;     // Mask of next shape at rows 0 to 1

    // A returned credit can be spent on the same edge
    assign credit_avail = credit + {1'b0, credit_return};
    assign fire         = (credit_avail != 2'd0);

    // Place the two shape rows at the top of an empty board
    always_comb begin
        shape_mask    = '0;
        shape_mask[0] = shape_rows[shape_idx][0];
        shape_mask[1] = shape_rows[shape_idx][1];
    end

    // Credit counter and strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit      <= 2'(max_credit);  // Faller starts empty
            spawn_valid <= 1'b0;
        end else begin
            spawn_valid <= fire;
            credit      <= credit_avail - {1'b0, fire};
        end
    end

    // Fixed rotating order 0..6
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            shape_idx <= '0;
        end else if (fire) begin
            if (shape_idx == shape_idx_t'(num_shapes - 1))
                shape_idx <= '0;  // Wrap after L
            else
                shape_idx <= shape_idx + 3'd1;
        end
    end

    // Payload, only meaningful with spawn_valid
    always_ff @(posedge clk) begin
        if (fire) begin
            spawn_piece.shape <= shape_idx;
            spawn_piece.mask  <= shape_mask;
        end
    end

endmodule

`default_nettype wire

// ==== tetris_pkg.sv ====
`default_nettype none

package tetris_pkg;

    // Board geometry
    localparam int board_rows = 22;
    localparam int board_cols = 10;
    localparam int num_shapes = 7;  // I O T S Z J L

    // Pieces the faller can hold at once
    localparam int max_credit = 1;

    // One row, bit 0 is the leftmost column
    typedef logic [board_cols-1:0] row_t;

    // Whole board, index 0 is the top row
    typedef row_t [board_rows-1:0] board_t;

    // Shape number 0 to 6
    typedef logic [2:0] shape_idx_t;

    // Cleared lines, wraps at 256
    typedef logic [7:0] line_count_t;

    // Piece as it moves between stages
    typedef struct packed {
        shape_idx_t shape;  // Which of the seven shapes
        board_t     mask;   // Occupied cells on the full board
    } piece_t;

    // Faller FSM
    typedef enum logic [1:0] {
        idle    = 2'b00,  // Waiting for a spawn
        falling = 2'b01,  // Live piece on the board
        over    = 2'b10   // Spawn blocked, game ended
    } fall_state_t;

    // Top two rows of each shape, placed in columns 3 to 6
    // Row 0 first, then row 1
    localparam row_t shape_rows [num_shapes][2] = '{
        '{10'b0001111000, 10'b0000000000},  // I, flat
        '{10'b0000110000, 10'b0000110000},  // O
        '{10'b0000111000, 10'b0000010000},  // T, pointing down
        '{10'b0000110000, 10'b0000011000},  // S
        '{10'b0000011000, 10'b0000110000},  // Z
        '{10'b0000001000, 10'b0000111000},  // J
        '{10'b0000100000, 10'b0000111000}   // L
    };

endpackage

`default_nettype wire
